// File: c16_keyboard.f
c16_kbd_pkg.sv
ps2_receiver.sv
scancode_fifo.sv
key_matrix.sv
keyboard_io.sv
reset_generator.sv
c16_keyboard.sv
c16_keyboard_checker.sv
tb_c16_keyboard.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_c16_keyboard -f c16_keyboard.f -o sim_c16_keyboard

# A failing run still leaves its log for the checks below
./obj_dir/sim_c16_keyboard > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
	echo "Simulation did not complete"
	exit 1
fi
echo "Simulation PASSED"

// File: tb_c16_keyboard.sv
module tb_c16_keyboard;

	timeunit 1ns;
	timeprecision 100ps;

	import c16_kbd_pkg::*;

	localparam int FIFO_DEPTH     = 8;
	localparam int RESET_HOLD     = 64;
	localparam int HALF_BIT       = 20;
	// Data setup cycle plus both clock halves for each of the eleven bits
	localparam int FRAME_CYCLES   = 11 * (2 * HALF_BIT + 1);
	localparam int N_ROUNDS       = 8;
	localparam int N_EVENTS       = 6;
	localparam int N_JOY          = 12;
	localparam int N_BAD          = 6;
	// Up to three bytes per key event, Ctrl+Alt+Del with releases, then the burst
	localparam int N_FRAMES       = N_ROUNDS * N_EVENTS * 3 + N_BAD + 9 + FIFO_DEPTH;
	localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 20000;

	logic       CLK28;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_data;
	logic [4:0] joy0, joy1;
	cpu_req_t   cpu_req;
	cpu_rsp_t   cpu_rsp;
	logic       sys_reset;

	// Reference model of the key matrix
	logic [7:0][7:0] model_pressed;
	logic            model_brk, model_ext;
	scancode_t       mapped[$];
	scancode_t       burst[$];

	int   error_count = 0;
	int   cycles = 0;
	logic sys_prev = 1'b0;
	int   rise_cycle = 0;
	int   fall_cycle = 0;
	int   release_cycle, start_cycle;
	logic [7:0] mask, wdata, rdata;

	c16_keyboard #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_HOLD(RESET_HOLD),
		.PS2_FILTER(4)
	) uut (
		.CLK28    (CLK28),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.joy0     (joy0),
		.joy1     (joy1),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.sys_reset(sys_reset)
	);

	// FIFO handshake nets live at the top level
	bind c16_keyboard c16_keyboard_checker #(.RESET_HOLD(RESET_HOLD)) u_checker (
		.CLK28(CLK28), .reset(reset),
		.rx_code(rx_code), .rx_valid(rx_valid), .rx_ready(rx_ready),
		.q_code(q_code), .q_valid(q_valid), .q_ready(q_ready),
		.key_reset(key_reset), .sys_reset(sys_reset)
	);

	initial begin
		CLK28 = 1'b0;
		forever #50 CLK28 = ~CLK28;
	end

	//////////////////////////////
	// Cycle count and watchdog
	//////////////////////////////

	always @(posedge CLK28) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$fatal(1, "Run stopped by the watchdog");
		end
	end

	// Edges of sys_reset stamped with the cycle count
	always @(negedge CLK28) begin
		sys_prev <= sys_reset;
		if (sys_reset === 1'b1 && sys_prev !== 1'b1)
			rise_cycle <= cycles;
		if (sys_reset === 1'b0 && sys_prev === 1'b1)
			fall_cycle <= cycles;
	end

	//////////////////////////////
	// Checks and model
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	// F0 marks a release, E0 an extended key that the matrix ignores
	task automatic model_apply(input scancode_t b);
		key_pos_t pos;
		pos = key_map[b];
		if (b == SC_BREAK) begin
			model_brk = 1'b1;
		end else if (b == SC_EXTEND) begin
			model_ext = 1'b1;
		end else begin
			if (!model_ext && pos.valid)
				model_pressed[pos.row][pos.col] = !model_brk;
			model_brk = 1'b0;
			model_ext = 1'b0;
		end
	endtask

	// Column reads low if a key in any selected row is down
	function automatic logic [7:0] model_kbus(input logic [7:0] rows);
		logic [7:0] kb;
		kb = 8'hFF;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 8; c++)
				if (!rows[r] && model_pressed[r][c])
					kb[c] = 1'b0;
		return kb;
	endfunction

	// Selected sticks pull direction lines 0-3, fire on 6 or 7
	function automatic logic [7:0] joy_merge(input logic [7:0] kb, input logic [4:0] j0,
		input logic [4:0] j1, input logic [7:0] sel);
		logic [7:0] res;
		res = kb;
		for (int d = 0; d < 4; d++) begin
			if (!sel[2] && j0[d])
				res[d] = 1'b0;
			if (!sel[1] && j1[d])
				res[d] = 1'b0;
		end
		if (!sel[2] && j0[4])
			res[6] = 1'b0;
		if (!sel[1] && j1[4])
			res[7] = 1'b0;
		return res;
	endfunction

	//////////////////////////////
	// Bus drivers
	//////////////////////////////

	// Start bit, eight data bits LSB first, odd parity, stop bit
	task automatic send_frame(input scancode_t b, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(negedge CLK28);
			ps2_data = bits[i];
			repeat (HALF_BIT) @(negedge CLK28);
			ps2_clk = 1'b0;
			repeat (HALF_BIT) @(negedge CLK28);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic send_byte(input scancode_t b);
		send_frame(b, 1'b0);
		model_apply(b);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge CLK28);
		cpu_req.addr   = addr;
		cpu_req.wdata  = data;
		cpu_req.rw     = 1'b0;
		cpu_req.strobe = 1'b1;
		@(negedge CLK28);
		cpu_req.strobe = 1'b0;
	endtask

	// Response is due exactly one cycle after the strobe
	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(negedge CLK28);
		cpu_req.addr   = addr;
		cpu_req.rw     = 1'b1;
		cpu_req.strobe = 1'b1;
		@(negedge CLK28);
		cpu_req.strobe = 1'b0;
		cpu_req.rw     = 1'b0;
		check_value("rd_valid", 32'(1'b1), 32'(cpu_rsp.rd_valid));
		data = cpu_rsp.rdata;
	endtask

	// Row mask, latch with sticks off, read back
	task automatic latch_check(input string name, input logic [7:0] rows);
		logic [7:0] got;
		cpu_write(16'hFD30, rows);
		cpu_write(KBD_LATCH_ADDR, 8'hFF);
		cpu_read(KBD_LATCH_ADDR, got);
		check_value(name, 32'(model_kbus(rows)), 32'(got));
	endtask

	// Each row alone, then all rows together
	task automatic check_matrix(input string name);
		for (int r = 0; r < 8; r++)
			latch_check(name, ~(8'h01 << r));
		latch_check(name, 8'h00);
	endtask

	task automatic key_event();
		scancode_t code;
		logic      ext, brk;
		code = mapped[$urandom_range(mapped.size() - 1, 0)];
		ext  = ($urandom_range(3, 0) == 0);
		brk  = ($urandom_range(1, 0) == 1);
		if (ext)
			send_byte(SC_EXTEND);
		if (brk)
			send_byte(SC_BREAK);
		send_byte(code);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		reset         = 1'b1;
		ps2_clk       = 1'b1;
		ps2_data      = 1'b1;
		joy0          = '0;
		joy1          = '0;
		cpu_req       = '0;
		model_pressed = '0;
		model_brk     = 1'b0;
		model_ext     = 1'b0;
		void'($urandom(86));
		for (int i = 0; i < 256; i++)
			if (key_map[i].valid)
				mapped.push_back(8'(i));

		// Reset stretch
		repeat (3) @(negedge CLK28);
		reset = 1'b0;
		release_cycle = cycles;
		check_value("reset_rd_valid", 32'(1'b0), 32'(cpu_rsp.rd_valid));
		while (sys_reset !== 1'b0)
			@(negedge CLK28);
		#1;
		check_value("reset_stretch", 32'(RESET_HOLD), 32'(fall_cycle - release_cycle));
		cpu_read(16'hFD30, rdata);
		check_value("reset_keyport", 32'(8'hFF), 32'(rdata));
		cpu_read(KBD_LATCH_ADDR, rdata);
		check_value("reset_latch", 32'(8'hFF), 32'(rdata));

		// Random presses and releases through any keyport address in the block
		for (int n = 0; n < N_ROUNDS; n++) begin
			for (int e = 0; e < N_EVENTS; e++)
				key_event();
			mask = 8'($urandom);
			cpu_write({KEYPORT_BASE, 4'($urandom)}, mask);
			joy0  = 5'($urandom);
			joy1  = 5'($urandom);
			wdata = 8'($urandom) | 8'h06;
			cpu_write(KBD_LATCH_ADDR, wdata);
			cpu_read(KBD_LATCH_ADDR, rdata);
			check_value("random_keys_latch", 32'(model_kbus(mask)), 32'(rdata));
			cpu_read(16'hFD30, rdata);
			check_value("random_keys_keyport", 32'(mask), 32'(rdata));
		end

		// Joystick merge
		for (int n = 0; n < N_JOY; n++) begin
			mask = 8'($urandom);
			cpu_write(16'hFD30, mask);
			joy0  = 5'($urandom);
			joy1  = 5'($urandom);
			wdata = 8'($urandom);
			cpu_write(KBD_LATCH_ADDR, wdata);
			cpu_read(KBD_LATCH_ADDR, rdata);
			check_value("joystick_merge", 32'(joy_merge(model_kbus(mask), joy0, joy1, wdata)),
				32'(rdata));
		end
		joy0 = '0;
		joy1 = '0;

		// Wrong parity never reaches the matrix
		for (int n = 0; n < N_BAD; n++) begin
			send_frame(mapped[$urandom_range(mapped.size() - 1, 0)], 1'b1);
			check_matrix("bad_parity");
		end

		// Ctrl+Alt+Del
		start_cycle = cycles;
		send_byte(SC_CTRL);
		send_byte(SC_ALT);
		send_byte(SC_DEL);
		model_pressed = '0;
		while (sys_reset !== 1'b1)
			@(negedge CLK28);
		while (sys_reset !== 1'b0)
			@(negedge CLK28);
		#1;
		check_value("cad_rise", 32'(1'b1), 32'(rise_cycle > start_cycle));
		check_value("cad_stretch", 32'(RESET_HOLD), 32'(fall_cycle - rise_cycle));
		check_matrix("cad_released");
		send_byte(SC_BREAK);
		send_byte(SC_CTRL);
		send_byte(SC_BREAK);
		send_byte(SC_ALT);
		send_byte(SC_BREAK);
		send_byte(SC_DEL);

		// Burst queued behind a held system reset
		check_value("burst_idle", 32'(1'b0), 32'(sys_reset));
		@(negedge CLK28);
		force uut.sys_reset = 1'b1;
		for (int n = 0; n < FIFO_DEPTH; n++) begin
			burst.push_back(mapped[$urandom_range(mapped.size() - 1, 0)]);
			send_frame(burst[n], 1'b0);
		end
		check_matrix("burst_held");
		@(negedge CLK28);
		release uut.sys_reset;
		// Matrix drains one code per cycle
		repeat (FIFO_DEPTH + 4) @(negedge CLK28);
		foreach (burst[i])
			model_apply(burst[i]);
		check_matrix("burst_applied");

		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: c16_keyboard_checker.sv
module c16_keyboard_checker #(
	parameter int RESET_HOLD = 64
) (
	input logic                   CLK28,
	input logic                   reset,
	input c16_kbd_pkg::scancode_t rx_code,
	input logic                   rx_valid,
	input logic                   rx_ready,
	input c16_kbd_pkg::scancode_t q_code,
	input logic                   q_valid,
	input logic                   q_ready,
	input logic                   key_reset,
	input logic                   sys_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// Edges seen since the last reset request, saturating at the hold length
	int since_req;

	//////////////////////////////
	// FIFO handshake
	//////////////////////////////

	// Receiver keeps its byte until the FIFO takes it
	rx_hold: assert property (@(posedge CLK28) disable iff (reset)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_code))
		else $error("Receiver byte changed or vanished while the FIFO was full");

	// FIFO head stays put while the matrix stalls
	q_hold: assert property (@(posedge CLK28) disable iff (reset)
		q_valid && !q_ready |=> q_valid && $stable(q_code))
		else $error("FIFO head changed or vanished without a pop");

	//////////////////////////////
	// Reset outputs
	//////////////////////////////

	// Button and Ctrl+Alt+Del both restart the count
	always_ff @(posedge CLK28) begin
		if (reset || key_reset)
			since_req <= 0;
		else if (since_req < RESET_HOLD)
			since_req <= since_req + 1;
	end

	// System reset covers the whole hold after any request
	reset_stretch: assert property (@(posedge CLK28) disable iff (reset)
		since_req < RESET_HOLD |-> sys_reset)
		else $error("System reset dropped before the hold time ran out");

endmodule

// File: c16_keyboard.sv
module c16_keyboard #(
	parameter int FIFO_DEPTH = 8,
	parameter int RESET_HOLD = 16777215,
	parameter int PS2_FILTER = 4
) (
	input  logic                  CLK28,
	input  logic                  reset,
	input  logic                  ps2_clk,
	input  logic                  ps2_data,
	input  logic [4:0]            joy0,
	input  logic [4:0]            joy1,
	input  c16_kbd_pkg::cpu_req_t cpu_req,
	output c16_kbd_pkg::cpu_rsp_t cpu_rsp,
	output logic                  sys_reset
);

	import c16_kbd_pkg::*;

	scancode_t  rx_code, q_code;
	logic       rx_valid, rx_ready;
	logic       q_valid, q_ready;
	logic [7:0] row_sel;
	logic [7:0] kbus_kbd;
	logic       key_reset;

	//////////////////////////////
	// Scan code path
	//////////////////////////////

	ps2_receiver #(
		.PS2_FILTER(PS2_FILTER)
	) u_ps2_receiver (
		.CLK28     (CLK28),
		.reset     (reset),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.code      (rx_code),
		.code_valid(rx_valid),
		.code_ready(rx_ready)
	);

	// Absorbs codes typed during a long system reset
	scancode_fifo #(
		.payload_t (scancode_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_scancode_fifo (
		.CLK28    (CLK28),
		.reset    (reset),
		.in_data  (rx_code),
		.in_valid (rx_valid),
		.in_ready (rx_ready),
		.out_data (q_code),
		.out_valid(q_valid),
		.out_ready(q_ready)
	);

	key_matrix u_key_matrix (
		.CLK28     (CLK28),
		.reset     (reset),
		.sys_reset (sys_reset),
		.code      (q_code),
		.code_valid(q_valid),
		.code_ready(q_ready),
		.row_sel   (row_sel),
		.kbus_kbd  (kbus_kbd),
		.key_reset (key_reset)
	);

	//////////////////////////////
	// CPU side and reset
	//////////////////////////////

	keyboard_io u_keyboard_io (
		.CLK28   (CLK28),
		.reset   (reset),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.joy0    (joy0),
		.joy1    (joy1),
		.row_sel (row_sel),
		.kbus_kbd(kbus_kbd)
	);

	// Button or Ctrl+Alt+Del
	reset_generator #(
		.RESET_HOLD(RESET_HOLD)
	) u_reset_generator (
		.CLK28    (CLK28),
		.reset    (reset),
		.key_reset(key_reset),
		.sys_reset(sys_reset)
	);

endmodule

// File: reset_generator.sv
module reset_generator #(
	parameter int RESET_HOLD = 16777215
) (
	input  logic CLK28,
	input  logic reset,
	input  logic key_reset,
	output logic sys_reset
);

	localparam int CNT_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD) : 1;

	logic [CNT_W-1:0] hold_cnt;

	// Every request restarts the count
	// Counter parks at the last value once released
	always_ff @(posedge CLK28) begin
		if (reset || key_reset) begin
			hold_cnt  <= '0;
			sys_reset <= 1'b1;
		end else if (hold_cnt == CNT_W'(RESET_HOLD - 1)) begin
			sys_reset <= 1'b0;
		end else begin
			hold_cnt  <= hold_cnt + 1'b1;
			sys_reset <= 1'b1;
		end
	end

endmodule

// File: keyboard_io.sv
module keyboard_io (
	input  logic                  CLK28,
	input  logic                  reset,
	input  c16_kbd_pkg::cpu_req_t cpu_req,
	output c16_kbd_pkg::cpu_rsp_t cpu_rsp,
	input  logic [4:0]            joy0,
	input  logic [4:0]            joy1,
	output logic [7:0]            row_sel,
	input  logic [7:0]            kbus_kbd
);

	import c16_kbd_pkg::*;

	logic [7:0] keyport;
	logic [7:0] latch;
	logic [7:0] kbus;
	logic [7:0] rd_data;
	logic       keyport_sel, latch_sel;
	logic       joy0_sel, joy1_sel;
	logic [3:0] joy0_dir, joy1_dir;

	// Address decode
	assign keyport_sel = (cpu_req.addr[15:4] == KEYPORT_BASE);
	assign latch_sel   = (cpu_req.addr == KBD_LATCH_ADDR);

	// Keyport output drives the rows directly
	assign row_sel = keyport;

	//////////////////////////////
	// Joystick merge
	//////////////////////////////

	// Select bits are active low in the written byte
	assign joy0_sel = !cpu_req.wdata[2];
	assign joy1_sel = !cpu_req.wdata[1];

	// Pressed direction pulls its line low
	assign joy0_dir = joy0_sel ? ~joy0[3:0] : 4'hF;
	assign joy1_dir = joy1_sel ? ~joy1[3:0] : 4'hF;

	assign kbus[3:0] = kbus_kbd[3:0] & joy0_dir & joy1_dir;
	// No joystick on these lines
	assign kbus[5:4] = kbus_kbd[5:4];
	// Fire buttons have a line each
	assign kbus[6]   = kbus_kbd[6] & !(joy0_sel && joy0[4]);
	assign kbus[7]   = kbus_kbd[7] & !(joy1_sel && joy1[4]);

	//////////////////////////////
	// Registers and read back
	//////////////////////////////

	always_ff @(posedge CLK28) begin
		if (reset) begin
			keyport <= 8'hFF;
			latch   <= 8'hFF;
		end else if (cpu_req.strobe && !cpu_req.rw) begin
			if (keyport_sel)
				keyport <= cpu_req.wdata;
			// Any write to $FF08 samples the bus
			if (latch_sel)
				latch <= kbus;
		end
	end

	// Unmapped addresses float high
	always_comb begin
		if (keyport_sel)
			rd_data = keyport;
		else if (latch_sel)
			rd_data = latch;
		else
			rd_data = 8'hFF;
	end

	always_ff @(posedge CLK28) begin
		if (reset)
			cpu_rsp.rd_valid <= 1'b0;
		else
			cpu_rsp.rd_valid <= cpu_req.strobe && cpu_req.rw;
	end

	always_ff @(posedge CLK28) begin
		if (cpu_req.strobe && cpu_req.rw)
			cpu_rsp.rdata <= rd_data;
	end

endmodule

// File: key_matrix.sv
module key_matrix (
	input  logic                   CLK28,
	input  logic                   reset,
	input  logic                   sys_reset,
	input  c16_kbd_pkg::scancode_t code,
	input  logic                   code_valid,
	output logic                   code_ready,
	input  logic [7:0]             row_sel,
	output logic [7:0]             kbus_kbd,
	output logic                   key_reset
);

	import c16_kbd_pkg::*;

	// pressed[row][col], one means held down
	logic [7:0][7:0] pressed;
	logic            brk, ext;
	logic            ctrl_held, alt_held;
	logic            take;
	key_pos_t        pos;

	// Codes wait in the FIFO while the system is in reset
	assign code_ready = !sys_reset;
	assign take       = code_valid && code_ready;
	assign pos        = key_map[code];

	//////////////////////////////
	// Scan code decode
	//////////////////////////////

	always_ff @(posedge CLK28) begin
		if (reset) begin
			brk       <= 1'b0;
			ext       <= 1'b0;
			ctrl_held <= 1'b0;
			alt_held  <= 1'b0;
			key_reset <= 1'b0;
		end else begin
			key_reset <= 1'b0;
			if (take) begin
				if (code == SC_BREAK) begin
					brk <= 1'b1;
				end else if (code == SC_EXTEND) begin
					ext <= 1'b1;
				end else begin
					// Left and right variants both count
					if (code == SC_CTRL)
						ctrl_held <= !brk;
					if (code == SC_ALT)
						alt_held <= !brk;
					// Del make with both modifiers down
					if (code == SC_DEL && !brk && ctrl_held && alt_held)
						key_reset <= 1'b1;
					brk <= 1'b0;
					ext <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// Matrix state
	//////////////////////////////

	// Extended keys and unmapped codes leave the matrix alone
	always_ff @(posedge CLK28) begin
		if (reset || key_reset) begin
			pressed <= '0;
		end else if (take && code != SC_BREAK && code != SC_EXTEND) begin
			if (!ext && pos.valid)
				pressed[pos.row][pos.col] <= !brk;
		end
	end

	// Column pulled low by any pressed key in a selected row
	always_comb begin
		kbus_kbd = '1;
		for (int r = 0; r < 8; r++) begin
			if (!row_sel[r])
				kbus_kbd = kbus_kbd & ~pressed[r];
		end
	end

endmodule

// File: scancode_fifo.sv
module scancode_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  FIFO_DEPTH = 8
) (
	input  logic     CLK28,
	input  logic     reset,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr, rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              push, pop;

	// Handshake on both sides
	assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// Head of queue
	assign out_data = mem[rd_ptr];

	always_ff @(posedge CLK28) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// Pointers wrap at depth, not at power of two
	always_ff @(posedge CLK28) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: ps2_receiver.sv
module ps2_receiver #(
	parameter int PS2_FILTER = 4
) (
	input  logic                  CLK28,
	input  logic                  reset,
	input  logic                  ps2_clk,
	input  logic                  ps2_data,
	output c16_kbd_pkg::scancode_t code,
	output logic                  code_valid,
	input  logic                  code_ready
);

	localparam int FILT_W = (PS2_FILTER > 1) ? $clog2(PS2_FILTER) : 1;

	logic              clk_meta, clk_sync, clk_filt;
	logic              data_meta, data_sync;
	logic [FILT_W-1:0] filt_cnt;
	logic              filt_done;
	logic              fall;
	logic [3:0]        bit_cnt;
	logic [9:0]        shift;
	logic              frame_ok;
	logic              frame_end;

	//////////////////////////////
	// Input synchronizers
	//////////////////////////////

	// Both lines idle high
	always_ff @(posedge CLK28) begin
		if (reset) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk;
			clk_sync  <= clk_meta;
			data_meta <= ps2_data;
			data_sync <= data_meta;
		end
	end

	// New level must hold for PS2_FILTER samples
	assign filt_done = (clk_sync != clk_filt) && (filt_cnt == FILT_W'(PS2_FILTER - 1));
	// Accepted transition to low
	assign fall = filt_done && !clk_sync;

	always_ff @(posedge CLK28) begin
		if (reset) begin
			clk_filt <= 1'b1;
			filt_cnt <= '0;
		end else if (clk_sync == clk_filt) begin
			filt_cnt <= '0;
		end else if (filt_done) begin
			clk_filt <= clk_sync;
			filt_cnt <= '0;
		end else begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Frame assembly
	//////////////////////////////

	// shift[0] start, shift[8:1] data, shift[9] parity
	// Stop bit is still on data_sync when the last edge comes
	assign frame_end = fall && (bit_cnt == 4'd10);
	assign frame_ok  = !shift[0] && (^shift[9:1]) && data_sync;

	always_ff @(posedge CLK28) begin
		if (reset) begin
			bit_cnt <= '0;
		end else if (fall) begin
			if (frame_end)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// LSB first, so bits enter at the top
	always_ff @(posedge CLK28) begin
		if (fall && !frame_end)
			shift <= {data_sync, shift[9:1]};
	end

	// Held byte blocks a new one unless it leaves this cycle
	always_ff @(posedge CLK28) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else begin
			if (code_valid && code_ready)
				code_valid <= 1'b0;
			if (frame_end && frame_ok && (!code_valid || code_ready))
				code_valid <= 1'b1;
		end
	end

	// Payload only
	always_ff @(posedge CLK28) begin
		if (frame_end && frame_ok && (!code_valid || code_ready))
			code <= shift[8:1];
	end

endmodule

// File: c16_kbd_pkg.sv
package c16_kbd_pkg;

	//////////////////////////////
	// CPU bus
	//////////////////////////////

	// One access per strobe, rw high means read
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rw;
		logic        strobe;
	} cpu_req_t;

	// Read data arrives one cycle after the strobe
	typedef struct packed {
		logic [7:0] rdata;
		logic       rd_valid;
	} cpu_rsp_t;

	// Raw PS/2 set 2 byte
	typedef logic [7:0] scancode_t;

	// Position of a key in the 8x8 matrix
	typedef struct packed {
		logic       valid;
		logic [2:0] row;
		logic [2:0] col;
	} key_pos_t;

	// Keyport decodes $FD30-$FD3F
	localparam logic [11:0] KEYPORT_BASE   = 12'hFD3;
	localparam logic [15:0] KBD_LATCH_ADDR = 16'hFF08;

	// Prefixes and keys with special handling
	localparam scancode_t SC_BREAK  = 8'hF0;
	localparam scancode_t SC_EXTEND = 8'hE0;
	localparam scancode_t SC_CTRL   = 8'h14;
	localparam scancode_t SC_ALT    = 8'h11;
	localparam scancode_t SC_DEL    = 8'h71;

	function automatic key_pos_t kp(input logic [2:0] row, input logic [2:0] col);
		key_pos_t pos;
		pos.valid = 1'b1;
		pos.row   = row;
		pos.col   = col;
		return pos;
	endfunction

	//////////////////////////////
	// Scan code to matrix
	//////////////////////////////

	// Row is the keyport bit, column is the kbus bit
	localparam key_pos_t key_map [256] = '{
		// Row 0, Return
		8'h5A: kp(3'd0, 3'd1),
		// Row 1, 3 W A 4 Z S E Shift
		8'h26: kp(3'd1, 3'd0), 8'h1D: kp(3'd1, 3'd1), 8'h1C: kp(3'd1, 3'd2), 8'h25: kp(3'd1, 3'd3),
		8'h1A: kp(3'd1, 3'd4), 8'h1B: kp(3'd1, 3'd5), 8'h24: kp(3'd1, 3'd6), 8'h12: kp(3'd1, 3'd7),
		// Right shift shares the left shift position
		8'h59: kp(3'd1, 3'd7),
		// Row 2, 5 R D 6 C F T X
		8'h2E: kp(3'd2, 3'd0), 8'h2D: kp(3'd2, 3'd1), 8'h23: kp(3'd2, 3'd2), 8'h36: kp(3'd2, 3'd3),
		8'h21: kp(3'd2, 3'd4), 8'h2B: kp(3'd2, 3'd5), 8'h2C: kp(3'd2, 3'd6), 8'h22: kp(3'd2, 3'd7),
		// Row 3, 7 Y G 8 B H U V
		8'h3D: kp(3'd3, 3'd0), 8'h35: kp(3'd3, 3'd1), 8'h34: kp(3'd3, 3'd2), 8'h3E: kp(3'd3, 3'd3),
		8'h32: kp(3'd3, 3'd4), 8'h33: kp(3'd3, 3'd5), 8'h3C: kp(3'd3, 3'd6), 8'h2A: kp(3'd3, 3'd7),
		// Row 4, 9 I J 0 M K O N
		8'h46: kp(3'd4, 3'd0), 8'h43: kp(3'd4, 3'd1), 8'h3B: kp(3'd4, 3'd2), 8'h45: kp(3'd4, 3'd3),
		8'h3A: kp(3'd4, 3'd4), 8'h42: kp(3'd4, 3'd5), 8'h44: kp(3'd4, 3'd6), 8'h31: kp(3'd4, 3'd7),
		// Row 5, P L
		8'h4D: kp(3'd5, 3'd1), 8'h4B: kp(3'd5, 3'd2),
		// Row 7, 1 Ctrl 2 Space Q
		8'h16: kp(3'd7, 3'd0), 8'h14: kp(3'd7, 3'd2), 8'h1E: kp(3'd7, 3'd3), 8'h29: kp(3'd7, 3'd4),
		8'h15: kp(3'd7, 3'd6),
		default: '0
	};

endpackage
